// ==== core_pkg.sv ====
package core_pkg;

  // ====================
  // widths and constants
  // ====================
  typedef logic [31:0] xlen_t;
  typedef logic [31:0] addr_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_idx_t;

  localparam inst_t NOP_INST = 32'h00000013;
  localparam addr_t RESET_PC = 32'h00000000;
  localparam addr_t PC_STEP  = 32'd4;

  // base opcodes, rv32i subset
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

  // ====================
  // enums
  // ====================
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_op_e;

  typedef enum logic [1:0] {RES_ALU, RES_MEM, RES_LINK} res_sel_e;

  typedef enum logic [1:0] {FWD_NONE, FWD_MEM, FWD_WB} fwd_sel_e;

  // ====================
  // pipeline structs
  // ====================
  typedef struct packed {
    logic     reg_write;
    logic     mem_write;
    logic     mem_read;
    logic     branch;
    logic     branch_ne;
    logic     jump;
    logic     jalr;
    logic     op1_pc;
    logic     op2_imm;
    alu_op_e  alu_op;
    res_sel_e res_sel;
  } ctrl_t;

  typedef struct packed {addr_t pc; addr_t pc_plus_4; inst_t inst;} if_id_t;

  typedef struct packed {
    addr_t pc; addr_t pc_plus_4;
    reg_idx_t rs1; reg_idx_t rs2; reg_idx_t rd;
    xlen_t rdata1; xlen_t rdata2; xlen_t imm;
    ctrl_t ctrl;
  } id_exe_t;

  typedef struct packed {
    addr_t pc_plus_4; addr_t target; xlen_t alu_result; logic zero;
    xlen_t store_data; reg_idx_t rd; ctrl_t ctrl;
  } exe_mem_t;

  // load data rides along so the wb mux sits after the register
  typedef struct packed {
    xlen_t result; xlen_t load_data; reg_idx_t rd; logic reg_write; logic load;
  } mem_wb_t;

endpackage

// ==== rv_fetch.sv ====
module rv_fetch
  import core_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n_i,
  input  logic   stall_i,
  input  logic   flush_i,
  input  logic   redirect_i,
  input  addr_t  redirect_pc_i,
  output addr_t  imem_addr_o,
  input  inst_t  imem_data_i,
  output if_id_t if_id_o
);

  addr_t pc;
  addr_t pc_plus_4;

  assign pc_plus_4   = pc + PC_STEP;
  assign imem_addr_o = pc;

  // redirect has priority over the load-use hold
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      pc <= RESET_PC;
    end else if (redirect_i) begin
      pc <= redirect_pc_i;
    end else if (!stall_i) begin
      pc <= pc_plus_4;
    end
  end

  // IF/ID register, nop on flush
  always_ff @(posedge clk) begin
    if (!rst_n_i || flush_i) begin
      if_id_o.inst <= NOP_INST;
    end else if (!stall_i) begin
      if_id_o.pc        <= pc;
      if_id_o.pc_plus_4 <= pc_plus_4;
      if_id_o.inst      <= imem_data_i;
    end
  end

endmodule

// ==== rv_reg_file.sv ====
module rv_reg_file
  import core_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n_i,
  input  reg_idx_t raddr1_i,
  input  reg_idx_t raddr2_i,
  output xlen_t    rdata1_o,
  output xlen_t    rdata2_o,
  input  logic     we_i,
  input  reg_idx_t waddr_i,
  input  xlen_t    wdata_i
);

  xlen_t regs [32];
  logic  wr_en;

  // x0 never written, no writes while in reset
  assign wr_en = we_i && rst_n_i && (waddr_i != '0);

  always_ff @(posedge clk) begin
    if (wr_en) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // write-first bypass covers the wb to decode path
  assign rdata1_o = (raddr1_i == '0) ? '0 : (wr_en && waddr_i == raddr1_i) ? wdata_i : regs[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 : (wr_en && waddr_i == raddr2_i) ? wdata_i : regs[raddr2_i];

endmodule

// ==== rv_decode.sv ====
module rv_decode
  import core_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n_i,
  input  if_id_t   if_id_i,
  input  logic     stall_i,
  input  logic     flush_i,
  input  logic     wb_we_i,
  input  reg_idx_t wb_rd_i,
  input  xlen_t    wb_data_i,
  output id_exe_t  id_exe_o
);

  inst_t      inst;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       f7_5;
  ctrl_t      ctrl;
  xlen_t      imm;
  xlen_t      rdata1;
  xlen_t      rdata2;
  id_exe_t    id_exe_d;

  assign inst   = if_id_i.inst;
  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign f7_5   = inst[30];

  rv_reg_file i_reg_file (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .raddr1_i (inst[19:15]),
    .raddr2_i (inst[24:20]),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2),
    .we_i     (wb_we_i),
    .waddr_i  (wb_rd_i),
    .wdata_i  (wb_data_i)
  );

  // ====================
  // main decoder
  // ====================
  always_comb begin
    ctrl = '0;
    case (opcode)
      OPC_OP, OPC_OP_IMM: begin
        ctrl.reg_write = 1'b1;
        ctrl.op2_imm   = (opcode == OPC_OP_IMM);
        case (funct3)
          3'b000:  ctrl.alu_op = (opcode == OPC_OP && f7_5) ? ALU_SUB : ALU_ADD;
          3'b001:  ctrl.alu_op = ALU_SLL;
          3'b010:  ctrl.alu_op = ALU_SLT;
          3'b011:  ctrl.alu_op = ALU_SLTU;
          3'b100:  ctrl.alu_op = ALU_XOR;
          3'b101:  ctrl.alu_op = f7_5 ? ALU_SRA : ALU_SRL;
          3'b110:  ctrl.alu_op = ALU_OR;
          default: ctrl.alu_op = ALU_AND;
        endcase
      end
      OPC_LUI: begin
        ctrl.reg_write = 1'b1;
        ctrl.op2_imm   = 1'b1;
        ctrl.alu_op    = ALU_PASS_B;
      end
      OPC_AUIPC: begin
        ctrl.reg_write = 1'b1;
        ctrl.op1_pc    = 1'b1;
        ctrl.op2_imm   = 1'b1;
      end
      OPC_LOAD: begin
        ctrl.reg_write = 1'b1;
        ctrl.mem_read  = 1'b1;
        ctrl.op2_imm   = 1'b1;
        ctrl.res_sel   = RES_MEM;
      end
      OPC_STORE: begin
        ctrl.mem_write = 1'b1;
        ctrl.op2_imm   = 1'b1;
      end
      OPC_BRANCH: begin
        // only beq/bne, funct3 bit 0 picks bne
        ctrl.branch    = 1'b1;
        ctrl.branch_ne = funct3[0];
        ctrl.alu_op    = ALU_SUB;
      end
      OPC_JAL, OPC_JALR: begin
        ctrl.reg_write = 1'b1;
        ctrl.jump      = 1'b1;
        ctrl.jalr      = (opcode == OPC_JALR);
        ctrl.res_sel   = RES_LINK;
      end
      default: ctrl = '0;
    endcase
  end

  // immediate generator
  always_comb begin
    case (opcode)
      OPC_STORE:          imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      OPC_BRANCH:         imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      OPC_LUI, OPC_AUIPC: imm = {inst[31:12], 12'h000};
      OPC_JAL:            imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      default:            imm = {{20{inst[31]}}, inst[31:20]};
    endcase
  end

  assign id_exe_d = '{pc: if_id_i.pc, pc_plus_4: if_id_i.pc_plus_4,
                      rs1: inst[19:15], rs2: inst[24:20], rd: inst[11:7],
                      rdata1: rdata1, rdata2: rdata2, imm: imm, ctrl: ctrl};

  // ID/EXE, bubble on stall or flush
  always_ff @(posedge clk) begin
    id_exe_o <= id_exe_d;
    if (!rst_n_i || flush_i || stall_i) begin
      id_exe_o.ctrl <= '0;
    end
  end

endmodule

// ==== rv_execute.sv ====
module rv_execute
  import core_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n_i,
  input  id_exe_t  id_exe_i,
  input  logic     flush_i,
  input  fwd_sel_e fwd_a_sel_i,
  input  fwd_sel_e fwd_b_sel_i,
  input  xlen_t    mem_result_i,
  input  xlen_t    wb_data_i,
  output exe_mem_t exe_mem_o
);

  xlen_t    src_a;
  xlen_t    src_b;
  xlen_t    op_a;
  xlen_t    op_b;
  xlen_t    alu_result;
  addr_t    target;
  addr_t    target_base;
  exe_mem_t exe_mem_d;

  function automatic xlen_t fwd_mux(fwd_sel_e sel, xlen_t reg_val, xlen_t mem_val,
                                    xlen_t wb_val);
    case (sel)
      FWD_MEM: return mem_val;
      FWD_WB:  return wb_val;
      default: return reg_val;
    endcase
  endfunction

  assign src_a = fwd_mux(fwd_a_sel_i, id_exe_i.rdata1, mem_result_i, wb_data_i);
  assign src_b = fwd_mux(fwd_b_sel_i, id_exe_i.rdata2, mem_result_i, wb_data_i);
  assign op_a  = id_exe_i.ctrl.op1_pc ? id_exe_i.pc : src_a;
  assign op_b  = id_exe_i.ctrl.op2_imm ? id_exe_i.imm : src_b;

  // ====================
  // alu
  // ====================
  always_comb begin
    case (id_exe_i.ctrl.alu_op)
      ALU_SUB:    alu_result = op_a - op_b;
      ALU_SLL:    alu_result = op_a << op_b[4:0];
      ALU_SLT:    alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   alu_result = {31'b0, op_a < op_b};
      ALU_XOR:    alu_result = op_a ^ op_b;
      ALU_SRL:    alu_result = op_a >> op_b[4:0];
      ALU_SRA:    alu_result = $signed(op_a) >>> op_b[4:0];
      ALU_OR:     alu_result = op_a | op_b;
      ALU_AND:    alu_result = op_a & op_b;
      ALU_PASS_B: alu_result = op_b;
      default:    alu_result = op_a + op_b;
    endcase
  end

  // jalr base is the forwarded rs1, bit 0 dropped
  assign target_base = id_exe_i.ctrl.jalr ? src_a : id_exe_i.pc;
  assign target      = (target_base + id_exe_i.imm) & ~addr_t'(1);

  assign exe_mem_d = '{pc_plus_4: id_exe_i.pc_plus_4, target: target,
                       alu_result: alu_result, zero: (alu_result == '0),
                       store_data: src_b, rd: id_exe_i.rd, ctrl: id_exe_i.ctrl};

  always_ff @(posedge clk) begin
    exe_mem_o <= exe_mem_d;
    if (!rst_n_i || flush_i) begin
      exe_mem_o.ctrl <= '0;
    end
  end

endmodule

// ==== rv_mem_wb.sv ====
module rv_mem_wb
  import core_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n_i,
  input  exe_mem_t exe_mem_i,
  output addr_t    dmem_addr_o,
  output xlen_t    dmem_wdata_o,
  output logic     dmem_we_o,
  output logic     dmem_re_o,
  input  xlen_t    dmem_rdata_i,
  output logic     redirect_o,
  output addr_t    redirect_pc_o,
  output xlen_t    mem_result_o,
  output logic     wb_we_o,
  output reg_idx_t wb_rd_o,
  output xlen_t    wb_data_o
);

  mem_wb_t mem_wb;

  // ====================
  // memory stage
  // ====================
  assign dmem_addr_o  = exe_mem_i.alu_result;
  assign dmem_wdata_o = exe_mem_i.store_data;
  assign dmem_we_o    = exe_mem_i.ctrl.mem_write;
  assign dmem_re_o    = exe_mem_i.ctrl.mem_read;

  // beq taken on zero, bne on nonzero
  assign redirect_o = exe_mem_i.ctrl.jump ||
                      (exe_mem_i.ctrl.branch && (exe_mem_i.zero ^ exe_mem_i.ctrl.branch_ne));
  assign redirect_pc_o = exe_mem_i.target;

  assign mem_result_o = (exe_mem_i.ctrl.res_sel == RES_LINK) ? exe_mem_i.pc_plus_4
                                                              : exe_mem_i.alu_result;

  always_ff @(posedge clk) begin
    mem_wb.result    <= mem_result_o;
    mem_wb.load_data <= dmem_rdata_i;
    mem_wb.rd        <= exe_mem_i.rd;
    mem_wb.load      <= (exe_mem_i.ctrl.res_sel == RES_MEM);
    mem_wb.reg_write <= rst_n_i && exe_mem_i.ctrl.reg_write;
  end

  // write-back mux
  assign wb_we_o   = mem_wb.reg_write;
  assign wb_rd_o   = mem_wb.rd;
  assign wb_data_o = mem_wb.load ? mem_wb.load_data : mem_wb.result;

endmodule

// ==== rv_hazard.sv ====
module rv_hazard
  import core_pkg::*;
(
  input  id_exe_t  id_exe_i,
  input  exe_mem_t exe_mem_i,
  input  logic     wb_we_i,
  input  reg_idx_t wb_rd_i,
  input  reg_idx_t if_rs1_i,
  input  reg_idx_t if_rs2_i,
  input  logic     redirect_i,
  output logic     stall_o,
  output logic     flush_o,
  output fwd_sel_e fwd_a_sel_o,
  output fwd_sel_e fwd_b_sel_o
);

  logic mem_fwd_ok;
  logic load_use;

  // a load in MEM has no data yet, the stall keeps it out of reach
  assign mem_fwd_ok = exe_mem_i.ctrl.reg_write && !exe_mem_i.ctrl.mem_read &&
                      (exe_mem_i.rd != '0);

  function automatic fwd_sel_e pick_fwd(reg_idx_t src, logic mem_ok, reg_idx_t mem_rd,
                                        logic wb_we, reg_idx_t wb_rd);
    if (mem_ok && mem_rd == src) return FWD_MEM;
    if (wb_we && wb_rd != '0 && wb_rd == src) return FWD_WB;
    return FWD_NONE;
  endfunction

  assign fwd_a_sel_o = pick_fwd(id_exe_i.rs1, mem_fwd_ok, exe_mem_i.rd, wb_we_i, wb_rd_i);
  assign fwd_b_sel_o = pick_fwd(id_exe_i.rs2, mem_fwd_ok, exe_mem_i.rd, wb_we_i, wb_rd_i);

  // load in EXE feeding the instruction in decode
  assign load_use = id_exe_i.ctrl.mem_read && (id_exe_i.rd != '0) &&
                    (id_exe_i.rd == if_rs1_i || id_exe_i.rd == if_rs2_i);

  assign stall_o = load_use && !redirect_i;
  assign flush_o = redirect_i;

endmodule

// ==== rv_core.sv ====
module rv_core
  import core_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n_i,
  output addr_t imem_addr_o,
  input  inst_t imem_data_i,
  output addr_t dmem_addr_o,
  output xlen_t dmem_wdata_o,
  output logic  dmem_we_o,
  output logic  dmem_re_o,
  input  xlen_t dmem_rdata_i
);

  if_id_t   if_id;
  id_exe_t  id_exe;
  exe_mem_t exe_mem;
  logic     stall;
  logic     flush;
  logic     redirect;
  addr_t    redirect_pc;
  fwd_sel_e fwd_a_sel;
  fwd_sel_e fwd_b_sel;
  xlen_t    mem_result;
  logic     wb_we;
  reg_idx_t wb_rd;
  xlen_t    wb_data;

  // ====================
  // pipeline stages
  // ====================
  rv_fetch i_fetch (
    .clk(clk), .rst_n_i(rst_n_i), .stall_i(stall), .flush_i(flush),
    .redirect_i(redirect), .redirect_pc_i(redirect_pc),
    .imem_addr_o(imem_addr_o), .imem_data_i(imem_data_i), .if_id_o(if_id)
  );

  rv_decode i_decode (
    .clk(clk), .rst_n_i(rst_n_i), .if_id_i(if_id), .stall_i(stall), .flush_i(flush),
    .wb_we_i(wb_we), .wb_rd_i(wb_rd), .wb_data_i(wb_data), .id_exe_o(id_exe)
  );

  rv_execute i_execute (
    .clk(clk), .rst_n_i(rst_n_i), .id_exe_i(id_exe), .flush_i(flush),
    .fwd_a_sel_i(fwd_a_sel), .fwd_b_sel_i(fwd_b_sel),
    .mem_result_i(mem_result), .wb_data_i(wb_data), .exe_mem_o(exe_mem)
  );

  rv_mem_wb i_mem_wb (
    .clk(clk), .rst_n_i(rst_n_i), .exe_mem_i(exe_mem),
    .dmem_addr_o(dmem_addr_o), .dmem_wdata_o(dmem_wdata_o), .dmem_we_o(dmem_we_o),
    .dmem_re_o(dmem_re_o), .dmem_rdata_i(dmem_rdata_i),
    .redirect_o(redirect), .redirect_pc_o(redirect_pc), .mem_result_o(mem_result),
    .wb_we_o(wb_we), .wb_rd_o(wb_rd), .wb_data_o(wb_data)
  );

  // hazard unit sees decode sources straight from IF/ID
  rv_hazard i_hazard (
    .id_exe_i(id_exe), .exe_mem_i(exe_mem), .wb_we_i(wb_we), .wb_rd_i(wb_rd),
    .if_rs1_i(if_id.inst[19:15]), .if_rs2_i(if_id.inst[24:20]), .redirect_i(redirect),
    .stall_o(stall), .flush_o(flush), .fwd_a_sel_o(fwd_a_sel), .fwd_b_sel_o(fwd_b_sel)
  );

endmodule

// ==== tb_rv_tasks.svh ====
`ifndef TB_RV_TASKS_SVH
`define TB_RV_TASKS_SVH

// ====================
// instruction encoders
// ====================
function automatic inst_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                logic [2:0] f3, reg_idx_t rd);
  return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic inst_t enc_i(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                reg_idx_t rd, logic [6:0] opc);
  return {imm, rs1, f3, rd, opc};
endfunction

function automatic inst_t enc_s(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1);
  return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
endfunction

function automatic inst_t enc_b(logic [12:0] off, reg_idx_t rs2, reg_idx_t rs1,
                                logic [2:0] f3);
  return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
endfunction

function automatic inst_t enc_u(logic [19:0] imm, reg_idx_t rd, logic [6:0] opc);
  return {imm, rd, opc};
endfunction

function automatic inst_t enc_j(logic [20:0] off, reg_idx_t rd);
  return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
endfunction

// ====================
// program builder
// ====================
function automatic addr_t next_pc();
  return addr_t'(prog.size() * 4);
endfunction

task automatic emit(inst_t inst);
  prog.push_back(inst);
endtask

// lui + addi, upper part rounded for the sign of the low 12 bits
task automatic load_const(reg_idx_t rd, xlen_t value);
  xlen_t upper;
  upper = (value + 32'h800) >> 12;
  emit(enc_u(upper[19:0], rd, OPC_LUI));
  emit(enc_i(value[11:0], rd, 3'b000, rd, OPC_OP_IMM));
endtask

task automatic store_word(reg_idx_t rs2, addr_t addr);
  emit(enc_s(addr[11:0], rs2, 5'd0));
endtask

task automatic expect_store(addr_t addr, xlen_t data);
  exp_addr.push_back(addr);
  exp_data.push_back(data);
endtask

// done marker then a self-jump
task automatic emit_finish();
  store_word(5'd0, DONE_ADDR);
  emit(enc_j(21'd0, 5'd0));
endtask

function automatic xlen_t xorshift();
  rng_state = rng_state ^ (rng_state << 13);
  rng_state = rng_state ^ (rng_state >> 17);
  rng_state = rng_state ^ (rng_state << 5);
  return rng_state;
endfunction

// ====================
// compare tasks
// ====================
task automatic check_word(xlen_t got, xlen_t exp, string what);
  if (got !== exp) begin
    $display("FAIL @%0t ns: %s got %h expected %h", $time, what, got, exp);
    stop_run();
  end
endtask

task automatic check_addr(addr_t got, addr_t exp, string what);
  if (got !== exp) begin
    $display("FAIL @%0t ns: %s address %h expected %h", $time, what, got, exp);
    stop_run();
  end
endtask

task automatic check_bit(logic got, logic exp, string what);
  if (got !== exp) begin
    $display("FAIL @%0t ns: %s is %b expected %b", $time, what, got, exp);
    stop_run();
  end
endtask

`endif

// ==== tb_rv_tests.svh ====
`ifndef TB_RV_TESTS_SVH
`define TB_RV_TESTS_SVH

function automatic logic [2:0] alu_f3(int k);
  case (k)
    0, 1:    return 3'b000;
    2:       return 3'b001;
    3:       return 3'b010;
    4:       return 3'b011;
    5:       return 3'b100;
    6, 7:    return 3'b101;
    8:       return 3'b110;
    default: return 3'b111;
  endcase
endfunction

function automatic logic [6:0] alu_f7(int k);
  return (k == 1 || k == 7) ? 7'h20 : 7'h00;
endfunction

// rv32i semantics of the register-register ops
function automatic xlen_t ref_alu(int k, xlen_t a, xlen_t b);
  case (k)
    0:       return a + b;
    1:       return a - b;
    2:       return a << b[4:0];
    3:       return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    4:       return (a < b) ? 32'd1 : 32'd0;
    5:       return a ^ b;
    6:       return a >> b[4:0];
    7:       return xlen_t'($signed(a) >>> b[4:0]);
    8:       return a | b;
    default: return a & b;
  endcase
endfunction

task automatic test_reset();
  @(negedge clk);
  rst_n = 1'b0;
  repeat (2) begin
    @(negedge clk);
    check_bit(dmem_we, 1'b0, "dmem_we in reset");
    check_bit(dmem_re, 1'b0, "dmem_re in reset");
    check_addr(imem_addr, RESET_PC, "imem_addr in reset");
  end
  rst_n = 1'b1;
  #1;
  check_bit(dmem_we, 1'b0, "dmem_we after reset");
  check_bit(dmem_re, 1'b0, "dmem_re after reset");
  check_addr(imem_addr, RESET_PC, "imem_addr after reset");
endtask

// accumulator in x3 chained through every op with x2
task automatic test_alu_chain();
  xlen_t a;
  xlen_t b;
  xlen_t acc;
  addr_t sa;
  begin_program();
  a = xorshift();
  b = xorshift();
  load_const(5'd1, a);
  load_const(5'd2, b);
  emit(enc_i(12'd0, 5'd1, 3'b000, 5'd3, OPC_OP_IMM));
  acc = a;
  for (int k = 0; k < 10; k++) begin
    emit(enc_r(alu_f7(k), 5'd2, 5'd3, alu_f3(k), 5'd3));
    acc = ref_alu(k, acc, b);
    sa = 32'h100 + addr_t'(k * 4);
    store_word(5'd3, sa);
    expect_store(sa, acc);
  end
  emit_finish();
  run_program("alu");
endtask

task automatic test_upper_imm();
  xlen_t u1;
  xlen_t u2;
  addr_t pc_auipc;
  begin_program();
  u1 = xorshift();
  u2 = xorshift();
  emit(enc_u(u1[19:0], 5'd5, OPC_LUI));
  store_word(5'd5, 32'h100);
  expect_store(32'h100, {u1[19:0], 12'h000});
  pc_auipc = next_pc();
  emit(enc_u(u2[19:0], 5'd6, OPC_AUIPC));
  store_word(5'd6, 32'h104);
  expect_store(32'h104, {u2[19:0], 12'h000} + pc_auipc);
  emit_finish();
  run_program("lui/auipc");
endtask

task automatic test_load_use();
  xlen_t c;
  xlen_t r1;
  xlen_t r2;
  begin_program();
  c  = xorshift();
  r1 = xorshift();
  r2 = xorshift();
  dmem[8'h80] = r1;
  dmem[8'h81] = r2;
  load_const(5'd7, c);
  emit(enc_i(12'h200, 5'd0, 3'b010, 5'd1, OPC_LOAD));
  emit(enc_r(7'h00, 5'd7, 5'd1, 3'b000, 5'd3));
  store_word(5'd3, 32'h100);
  emit(enc_i(12'h204, 5'd0, 3'b010, 5'd2, OPC_LOAD));
  emit(enc_r(7'h00, 5'd3, 5'd2, 3'b000, 5'd4));
  store_word(5'd4, 32'h104);
  expect_store(32'h100, r1 + c);
  expect_store(32'h104, r2 + r1 + c);
  emit_finish();
  run_program("load");
endtask

// beq taken, beq not taken, bne taken, bne not taken
task automatic test_branches();
  logic [2:0] f3;
  reg_idx_t   rs2;
  logic       taken;
  addr_t      sa;
  begin_program();
  emit(enc_i(12'd5, 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
  emit(enc_i(12'd5, 5'd0, 3'b000, 5'd2, OPC_OP_IMM));
  emit(enc_i(12'd7, 5'd0, 3'b000, 5'd3, OPC_OP_IMM));
  for (int c = 0; c < 4; c++) begin
    f3    = (c < 2) ? 3'b000 : 3'b001;
    rs2   = (c == 0 || c == 3) ? 5'd2 : 5'd3;
    taken = (f3 == 3'b000) ? (rs2 == 5'd2) : (rs2 != 5'd2);
    emit(enc_b(13'd16, rs2, 5'd1, f3));
    for (int j = 0; j < 3; j++) begin
      sa = 32'h100 + addr_t'(c * 16 + j * 4);
      store_word(5'd1, sa);
      if (!taken) begin
        expect_store(sa, 32'd5);
      end
    end
    sa = 32'h180 + addr_t'(c * 4);
    store_word(5'd3, sa);
    expect_store(sa, 32'd7);
  end
  emit_finish();
  run_program("branch");
endtask

task automatic test_jumps();
  addr_t pc_jal;
  addr_t pc_jalr;
  addr_t tgt;
  begin_program();
  pc_jal = next_pc();
  emit(enc_j(21'd16, 5'd5));
  for (int j = 0; j < 3; j++) begin
    store_word(5'd5, 32'h140 + addr_t'(j * 4));
  end
  store_word(5'd5, 32'h100);
  expect_store(32'h100, pc_jal + 32'd4);
  tgt = next_pc() + 32'd20;
  emit(enc_i(tgt[11:0], 5'd0, 3'b000, 5'd6, OPC_OP_IMM));
  pc_jalr = next_pc();
  emit(enc_i(12'd0, 5'd6, 3'b000, 5'd7, OPC_JALR));
  for (int j = 0; j < 3; j++) begin
    store_word(5'd7, 32'h150 + addr_t'(j * 4));
  end
  store_word(5'd7, 32'h104);
  expect_store(32'h104, pc_jalr + 32'd4);
  emit_finish();
  run_program("jump");
endtask

`endif

// ==== tb_rv_core.sv ====
module tb_rv_core
  import core_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int    CLK_PERIOD = 4;
  localparam int    RUN_LIMIT  = 300;
  localparam int    NUM_RUNS   = 6;
  localparam addr_t DONE_ADDR  = 32'h3fc;

  logic  clk;
  logic  rst_n;
  addr_t imem_addr;
  inst_t imem_data;
  addr_t dmem_addr;
  xlen_t dmem_wdata;
  logic  dmem_we;
  logic  dmem_re;
  xlen_t dmem_rdata;

  inst_t imem [256];
  xlen_t dmem [256];
  inst_t prog [$];
  addr_t st_addr [$];
  xlen_t st_data [$];
  addr_t exp_addr [$];
  xlen_t exp_data [$];
  logic  done_seen;
  logic [31:0] rng_state;

  rv_core i_dut (
    .clk(clk), .rst_n_i(rst_n), .imem_addr_o(imem_addr), .imem_data_i(imem_data),
    .dmem_addr_o(dmem_addr), .dmem_wdata_o(dmem_wdata), .dmem_we_o(dmem_we),
    .dmem_re_o(dmem_re), .dmem_rdata_i(dmem_rdata)
  );

  task automatic stop_run();
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  `include "tb_rv_tasks.svh"

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ====================
  // memory models
  // ====================
  assign imem_data  = imem[imem_addr[9:2]];

  // inverted word unless the read strobe is high
  assign dmem_rdata = (dmem_re === 1'b1) ? dmem[dmem_addr[9:2]] : ~dmem[dmem_addr[9:2]];

  // stores sampled mid-cycle where the bus is stable
  always @(negedge clk) begin
    if (dmem_we === 1'b1) begin
      dmem[dmem_addr[9:2]] = dmem_wdata;
      if (dmem_addr == DONE_ADDR) begin
        done_seen = 1'b1;
      end else begin
        st_addr.push_back(dmem_addr);
        st_data.push_back(dmem_wdata);
      end
    end
  end

  initial begin
    #((NUM_RUNS * (RUN_LIMIT + 4) + 50) * CLK_PERIOD);
    $display("watchdog expired before the test sequence finished");
    stop_run();
  end

  // new program with data memory filled from the full address
  task automatic begin_program();
    prog.delete();
    exp_addr.delete();
    exp_data.delete();
    for (int i = 0; i < 256; i++) begin
      dmem[i] = 32'hd0000000 ^ xlen_t'(i * 4);
    end
  endtask

  task automatic run_program(string name);
    int cycles;
    cycles = 0;
    @(negedge clk);
    rst_n = 1'b0;
    for (int i = 0; i < 256; i++) begin
      imem[i] = (i < prog.size()) ? prog[i] : NOP_INST;
    end
    st_addr.delete();
    st_data.delete();
    done_seen = 1'b0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    while (!done_seen && cycles < RUN_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    if (!done_seen) begin
      $display("%s program never reached its done store within %0d cycles", name, RUN_LIMIT);
      stop_run();
    end
    check_word(xlen_t'(st_data.size()), xlen_t'(exp_data.size()), {name, " store count"});
    for (int i = 0; i < exp_data.size(); i++) begin
      check_addr(st_addr[i], exp_addr[i], {name, " store"});
      check_word(st_data[i], exp_data[i], {name, " store data"});
    end
  endtask

  `include "tb_rv_tests.svh"

  initial begin
    rst_n     = 1'b0;
    done_seen = 1'b0;
    rng_state = 32'h29f8b9f4;
    for (int i = 0; i < 256; i++) begin
      imem[i] = NOP_INST;
      dmem[i] = '0;
    end
    test_reset();
    test_alu_chain();
    test_upper_imm();
    test_load_use();
    test_branches();
    test_jumps();
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// ==== rv_core.f ====
+incdir+.
core_pkg.sv
rv_fetch.sv
rv_reg_file.sv
rv_decode.sv
rv_execute.sv
rv_mem_wb.sv
rv_hazard.sv
rv_core.sv
tb_rv_core.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f rv_core.f --top-module tb_rv_core -o sim_tb_rv_core

# the simulator exits nonzero on a failure, the search below decides
out=$(./obj_dir/sim_tb_rv_core 2>&1 || true)
echo "$out"

if echo "$out" | grep -q "TEST RESULT: PASS"; then
  exit 0
else
  exit 1
fi
